// ==== Bender.yml ====
package:
  name: pipelined_cpu

sources:
  - hw/cpu_pkg.sv
  - hw/unified_mem.sv
  - hw/mem_arbiter.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/mem_stage.sv
  - hw/cpu.sv
  - target: test
    files:
      - testbench/cpu_checker.sv
      - testbench/tb_cpu.sv

// ==== hw/cpu.sv ====
`timescale 1ns/1ns

module cpu #(
	parameter int addr_w = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              run,
	input  logic              ext_req,
	input  logic              ext_we,
	input  logic [addr_w-1:0] ext_addr,
	input  cpu_pkg::word_t    ext_wdata,
	output cpu_pkg::word_t    ext_rdata,
	output logic              ext_gnt,
	output logic              hlt,
	output cpu_pkg::word_t    pc
);

	// IF side
	logic               fetch_req, fetch_gnt, valid_id, stall_if;
	logic [addr_w-1:0]  fetch_addr;
	cpu_pkg::word_t     fetch_rdata, instr_id, pc_id;
	// ID/EX
	cpu_pkg::word_t     op_a_ex, op_b_ex, data_ex, pc_ex;
	logic [7:0]         imm8_ex;
	cpu_pkg::opcode_t   opcode_ex;
	cpu_pkg::reg_addr_t dst_ex;
	logic               we_rf_ex, valid_ex;
	// EX/MEM and branch
	logic               br_taken, we_rf_mem, valid_mem;
	cpu_pkg::word_t     br_pc, result_mem, sdata_mem;
	cpu_pkg::opcode_t   opcode_mem;
	cpu_pkg::reg_addr_t dst_mem;
	// Data port and writeback
	logic               data_req, data_we, wb_we;
	logic [addr_w-1:0]  data_addr;
	cpu_pkg::word_t     data_wdata, data_rdata, wb_data;
	cpu_pkg::reg_addr_t wb_dst;
	// Memory port
	logic               mem_we;
	logic [addr_w-1:0]  mem_addr;
	cpu_pkg::word_t     mem_wdata, mem_rdata;

	//////////////////////////////
	// Pipeline
	//////////////////////////////

	fetch_stage #(.addr_w(addr_w)) fetch_i (
		.clk(clk), .rst_n(rst_n), .run(run), .hlt(hlt),
		.stall_if(stall_if), .br_taken(br_taken), .br_pc(br_pc),
		.fetch_gnt(fetch_gnt), .fetch_rdata(fetch_rdata),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr), .pc(pc),
		.instr_id(instr_id), .pc_id(pc_id), .valid_id(valid_id)
	);

	decode_stage decode_i (
		.clk(clk), .rst_n(rst_n),
		.instr_id(instr_id), .pc_id(pc_id), .valid_id(valid_id), .br_taken(br_taken),
		.dst_mem(dst_mem), .we_rf_mem(we_rf_mem), .valid_mem(valid_mem),
		.wb_we(wb_we), .wb_dst(wb_dst), .wb_data(wb_data),
		.stall_if(stall_if), .op_a_ex(op_a_ex), .op_b_ex(op_b_ex), .data_ex(data_ex),
		.imm8_ex(imm8_ex), .opcode_ex(opcode_ex), .dst_ex(dst_ex),
		.we_rf_ex(we_rf_ex), .valid_ex(valid_ex), .pc_ex(pc_ex)
	);

	execute_stage execute_i (
		.clk(clk), .rst_n(rst_n),
		.op_a_ex(op_a_ex), .op_b_ex(op_b_ex), .data_ex(data_ex), .imm8_ex(imm8_ex),
		.opcode_ex(opcode_ex), .dst_ex(dst_ex), .we_rf_ex(we_rf_ex),
		.valid_ex(valid_ex), .pc_ex(pc_ex),
		.br_taken(br_taken), .br_pc(br_pc), .result_mem(result_mem),
		.sdata_mem(sdata_mem), .opcode_mem(opcode_mem), .dst_mem(dst_mem),
		.we_rf_mem(we_rf_mem), .valid_mem(valid_mem)
	);

	mem_stage #(.addr_w(addr_w)) mem_i (
		.clk(clk), .rst_n(rst_n),
		.result_mem(result_mem), .sdata_mem(sdata_mem), .opcode_mem(opcode_mem),
		.dst_mem(dst_mem), .we_rf_mem(we_rf_mem), .valid_mem(valid_mem),
		.data_rdata(data_rdata),
		.data_req(data_req), .data_we(data_we), .data_addr(data_addr),
		.data_wdata(data_wdata), .wb_we(wb_we), .wb_dst(wb_dst),
		.wb_data(wb_data), .hlt(hlt)
	);

	//////////////////////////////
	// Shared memory
	//////////////////////////////

	mem_arbiter #(.addr_w(addr_w)) arb_i (
		.clk(clk), .rst_n(rst_n),
		.ext_req(ext_req), .ext_we(ext_we), .ext_addr(ext_addr),
		.ext_wdata(ext_wdata), .ext_rdata(ext_rdata), .ext_gnt(ext_gnt),
		.data_req(data_req), .data_we(data_we), .data_addr(data_addr),
		.data_wdata(data_wdata), .data_rdata(data_rdata),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.fetch_rdata(fetch_rdata), .fetch_gnt(fetch_gnt),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	unified_mem #(.addr_w(addr_w)) mem_array_i (
		.clk(clk), .we(mem_we), .addr(mem_addr),
		.wdata(mem_wdata), .rdata(mem_rdata)
	);

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	// Widths set by the instruction set
	localparam int word_w  = 16;
	localparam int reg_num = 16;

	// Data and instruction word
	typedef logic [word_w-1:0] word_t;

	// Register file index
	typedef logic [$clog2(reg_num)-1:0] reg_addr_t;

	// Top nibble of every instruction
	// Codes not listed here decode as no-ops
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_NOR  = 4'd3,
		OP_LLB  = 4'd4,
		OP_LW   = 4'd5,
		OP_SW   = 4'd6,
		OP_BEQZ = 4'd7,
		OP_HLT  = 4'd15
	} opcode_t;

	// Current owner of the single memory port
	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_EXT,
		OWN_DATA,
		OWN_FETCH
	} mem_owner_t;

endpackage

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  cpu_pkg::word_t      instr_id,
	input  cpu_pkg::word_t      pc_id,
	input  logic                valid_id,
	input  logic                br_taken,
	input  cpu_pkg::reg_addr_t  dst_mem,
	input  logic                we_rf_mem,
	input  logic                valid_mem,
	input  logic                wb_we,
	input  cpu_pkg::reg_addr_t  wb_dst,
	input  cpu_pkg::word_t      wb_data,
	output logic                stall_if,
	output cpu_pkg::word_t      op_a_ex,
	output cpu_pkg::word_t      op_b_ex,
	output cpu_pkg::word_t      data_ex,
	output logic [7:0]          imm8_ex,
	output cpu_pkg::opcode_t    opcode_ex,
	output cpu_pkg::reg_addr_t  dst_ex,
	output logic                we_rf_ex,
	output logic                valid_ex,
	output cpu_pkg::word_t      pc_ex
);

	cpu_pkg::word_t     regs [cpu_pkg::reg_num];
	cpu_pkg::opcode_t   opcode;
	cpu_pkg::reg_addr_t rd, rs, rt;
	cpu_pkg::word_t     rf_rs, rf_rt, rf_rd, op_b;
	logic use_rs, use_rt, use_rd, we_rf;
	logic busy_rs, busy_rt, busy_rd;
	logic raw, issue, halting;

	// Field split
	assign opcode = cpu_pkg::opcode_t'(instr_id[15:12]);
	assign rd     = instr_id[11:8];
	assign rs     = instr_id[7:4];
	assign rt     = instr_id[3:0];

	//////////////////////////////
	// Register file
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (wb_we)
			regs[wb_dst] <= wb_data;
	end

	// Writeback in the same cycle passes straight through
	assign rf_rs = (wb_we && wb_dst == rs) ? wb_data : regs[rs];
	assign rf_rt = (wb_we && wb_dst == rt) ? wb_data : regs[rt];
	assign rf_rd = (wb_we && wb_dst == rd) ? wb_data : regs[rd];

	// Sources and second operand per opcode
	always_comb begin
		use_rs = 1'b0;
		use_rt = 1'b0;
		use_rd = 1'b0;
		we_rf  = 1'b0;
		op_b   = rf_rt;
		case (opcode)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_NOR: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				we_rf  = 1'b1;
			end
			cpu_pkg::OP_LLB:
				we_rf = 1'b1;
			cpu_pkg::OP_LW: begin
				// rt is an unsigned offset here
				use_rs = 1'b1;
				we_rf  = 1'b1;
				op_b   = {12'd0, rt};
			end
			cpu_pkg::OP_SW: begin
				// Store data comes from rd
				use_rs = 1'b1;
				use_rd = 1'b1;
				op_b   = {12'd0, rt};
			end
			cpu_pkg::OP_BEQZ:
				use_rd = 1'b1;
			default: ;
		endcase
	end

	//////////////////////////////
	// Hazards
	//////////////////////////////

	// Pending write in EX or MEM
	assign busy_rs = (valid_ex && we_rf_ex && dst_ex == rs) ||
		(valid_mem && we_rf_mem && dst_mem == rs);
	assign busy_rt = (valid_ex && we_rf_ex && dst_ex == rt) ||
		(valid_mem && we_rf_mem && dst_mem == rt);
	assign busy_rd = (valid_ex && we_rf_ex && dst_ex == rd) ||
		(valid_mem && we_rf_mem && dst_mem == rd);

	assign raw = valid_id &&
		((use_rs && busy_rs) || (use_rt && busy_rt) || (use_rd && busy_rd));

	assign stall_if = halting || raw;

	// Taken branch turns this slot into a bubble
	assign issue = valid_id && !raw && !halting && !br_taken;

	// ID/EX control and halt latch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_ex <= 1'b0;
			halting  <= 1'b0;
		end else begin
			valid_ex <= issue;
			if (issue && opcode == cpu_pkg::OP_HLT)
				halting <= 1'b1;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		op_a_ex   <= rf_rs;
		op_b_ex   <= op_b;
		data_ex   <= rf_rd;
		imm8_ex   <= instr_id[7:0];
		opcode_ex <= opcode;
		dst_ex    <= rd;
		we_rf_ex  <= we_rf;
		pc_ex     <= pc_id;
	end

	// Once halting only the HLT itself is valid in EX
	assert property (@(posedge clk) disable iff (!rst_n)
		(halting && valid_ex) |-> opcode_ex == cpu_pkg::OP_HLT);

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  cpu_pkg::word_t      op_a_ex,
	input  cpu_pkg::word_t      op_b_ex,
	input  cpu_pkg::word_t      data_ex,
	input  logic [7:0]          imm8_ex,
	input  cpu_pkg::opcode_t    opcode_ex,
	input  cpu_pkg::reg_addr_t  dst_ex,
	input  logic                we_rf_ex,
	input  logic                valid_ex,
	input  cpu_pkg::word_t      pc_ex,
	output logic                br_taken,
	output cpu_pkg::word_t      br_pc,
	output cpu_pkg::word_t      result_mem,
	output cpu_pkg::word_t      sdata_mem,
	output cpu_pkg::opcode_t    opcode_mem,
	output cpu_pkg::reg_addr_t  dst_mem,
	output logic                we_rf_mem,
	output logic                valid_mem
);

	cpu_pkg::word_t imm_sx, alu;

	assign imm_sx = {{8{imm8_ex[7]}}, imm8_ex};

	// ALU, all results wrap at 16 bits
	always_comb begin
		case (opcode_ex)
			cpu_pkg::OP_ADD: alu = op_a_ex + op_b_ex;
			cpu_pkg::OP_SUB: alu = op_a_ex - op_b_ex;
			cpu_pkg::OP_AND: alu = op_a_ex & op_b_ex;
			cpu_pkg::OP_NOR: alu = ~(op_a_ex | op_b_ex);
			cpu_pkg::OP_LLB: alu = imm_sx;
			// Effective address, base plus offset
			cpu_pkg::OP_LW, cpu_pkg::OP_SW: alu = op_a_ex + op_b_ex;
			default: alu = '0;
		endcase
	end

	// BEQZ resolves here, pc_ex is already pc plus 1
	assign br_taken = valid_ex && opcode_ex == cpu_pkg::OP_BEQZ && data_ex == '0;
	assign br_pc    = pc_ex + imm_sx;

	// EX/MEM control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_mem <= 1'b0;
		else
			valid_mem <= valid_ex;
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		result_mem <= alu;
		sdata_mem  <= data_ex;
		opcode_mem <= opcode_ex;
		dst_mem    <= dst_ex;
		we_rf_mem  <= we_rf_ex;
	end

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage #(
	parameter int addr_w = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              run,
	input  logic              hlt,
	input  logic              stall_if,
	input  logic              br_taken,
	input  cpu_pkg::word_t    br_pc,
	input  logic              fetch_gnt,
	input  cpu_pkg::word_t    fetch_rdata,
	output logic              fetch_req,
	output logic [addr_w-1:0] fetch_addr,
	output cpu_pkg::word_t    pc,
	output cpu_pkg::word_t    instr_id,
	output cpu_pkg::word_t    pc_id,
	output logic              valid_id
);

	logic take;

	// No request while stopped, halted or stalled
	assign fetch_req  = run && !hlt && !stall_if;
	assign fetch_addr = pc[addr_w-1:0];
	assign take       = fetch_req && fetch_gnt;

	// PC and IF/ID valid
	// Branch wins over stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc       <= '0;
			valid_id <= 1'b0;
		end else if (br_taken) begin
			pc       <= br_pc;
			valid_id <= 1'b0;
		end else if (!stall_if) begin
			// Lost grant gives a bubble and pc holds
			valid_id <= take;
			if (take)
				pc <= pc + 16'd1;
		end
	end

	// IF/ID payload
	always_ff @(posedge clk) begin
		if (take && !br_taken) begin
			instr_id <= fetch_rdata;
			pc_id    <= pc + 16'd1;
		end
	end

	// IF/ID only fills from a granted fetch
	assert property (@(posedge clk) disable iff (!rst_n)
		!fetch_gnt |=> !$rose(valid_id));

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter #(
	parameter int addr_w = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	// External load/inspect port
	input  logic              ext_req,
	input  logic              ext_we,
	input  logic [addr_w-1:0] ext_addr,
	input  cpu_pkg::word_t    ext_wdata,
	output cpu_pkg::word_t    ext_rdata,
	output logic              ext_gnt,
	// Memory stage
	input  logic              data_req,
	input  logic              data_we,
	input  logic [addr_w-1:0] data_addr,
	input  cpu_pkg::word_t    data_wdata,
	output cpu_pkg::word_t    data_rdata,
	// Instruction fetch is read only
	input  logic              fetch_req,
	input  logic [addr_w-1:0] fetch_addr,
	output cpu_pkg::word_t    fetch_rdata,
	output logic              fetch_gnt,
	// Memory side
	output logic              mem_we,
	output logic [addr_w-1:0] mem_addr,
	output cpu_pkg::word_t    mem_wdata,
	input  cpu_pkg::word_t    mem_rdata
);

	cpu_pkg::mem_owner_t owner;
	logic data_gnt;

	// Fixed priority of EXT over DATA over FETCH
	always_comb begin
		if (ext_req)
			owner = cpu_pkg::OWN_EXT;
		else if (data_req)
			owner = cpu_pkg::OWN_DATA;
		else if (fetch_req)
			owner = cpu_pkg::OWN_FETCH;
		else
			owner = cpu_pkg::OWN_NONE;
	end

	assign ext_gnt   = (owner == cpu_pkg::OWN_EXT);
	assign data_gnt  = (owner == cpu_pkg::OWN_DATA);
	assign fetch_gnt = (owner == cpu_pkg::OWN_FETCH);

	// Steer the winner onto the port
	always_comb begin
		mem_we    = 1'b0;
		mem_addr  = fetch_addr;
		mem_wdata = data_wdata;
		case (owner)
			cpu_pkg::OWN_EXT: begin
				mem_we    = ext_we;
				mem_addr  = ext_addr;
				mem_wdata = ext_wdata;
			end
			cpu_pkg::OWN_DATA: begin
				mem_we    = data_we;
				mem_addr  = data_addr;
			end
			default: ;
		endcase
	end

	// Read data fans out to every requester
	assign ext_rdata   = mem_rdata;
	assign data_rdata  = mem_rdata;
	assign fetch_rdata = mem_rdata;

	// Any request leaves exactly one owner
	assert property (@(posedge clk) disable iff (!rst_n)
		(ext_req || data_req || fetch_req) |-> $onehot({ext_gnt, data_gnt, fetch_gnt}));

	// External port only used while the core is idle
	assert property (@(posedge clk) disable iff (!rst_n)
		!(data_req && ext_req));

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage #(
	parameter int addr_w = 8
) (
	input  logic                clk,
	input  logic                rst_n,
	input  cpu_pkg::word_t      result_mem,
	input  cpu_pkg::word_t      sdata_mem,
	input  cpu_pkg::opcode_t    opcode_mem,
	input  cpu_pkg::reg_addr_t  dst_mem,
	input  logic                we_rf_mem,
	input  logic                valid_mem,
	input  cpu_pkg::word_t      data_rdata,
	output logic                data_req,
	output logic                data_we,
	output logic [addr_w-1:0]   data_addr,
	output cpu_pkg::word_t      data_wdata,
	output logic                wb_we,
	output cpu_pkg::reg_addr_t  wb_dst,
	output cpu_pkg::word_t      wb_data,
	output logic                hlt
);

	logic is_lw, is_sw;

	assign is_lw = valid_mem && opcode_mem == cpu_pkg::OP_LW;
	assign is_sw = valid_mem && opcode_mem == cpu_pkg::OP_SW;

	// Data port, never refused by the arbiter
	assign data_req   = is_lw || is_sw;
	assign data_we    = is_sw;
	assign data_addr  = result_mem[addr_w-1:0];
	assign data_wdata = sdata_mem;

	// MEM/WB control, hlt sticky until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_we <= 1'b0;
			hlt   <= 1'b0;
		end else begin
			wb_we <= valid_mem && we_rf_mem;
			if (valid_mem && opcode_mem == cpu_pkg::OP_HLT)
				hlt <= 1'b1;
		end
	end

	// MEM/WB payload, load data or ALU result
	always_ff @(posedge clk) begin
		wb_dst  <= dst_mem;
		wb_data <= is_lw ? data_rdata : result_mem;
	end

endmodule

// ==== hw/unified_mem.sv ====
`timescale 1ns/1ns

module unified_mem #(
	parameter int addr_w = 8
) (
	input  logic              clk,
	input  logic              we,
	input  logic [addr_w-1:0] addr,
	input  cpu_pkg::word_t    wdata,
	output cpu_pkg::word_t    rdata
);

	// Program and data share this array
	// Contents survive reset
	cpu_pkg::word_t mem [2**addr_w];

	// Write on the edge
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	// Read is combinational, same cycle as the grant
	assign rdata = mem[addr];

endmodule

// ==== src.f ====
hw/cpu_pkg.sv
hw/unified_mem.sv
hw/mem_arbiter.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/cpu.sv
testbench/cpu_checker.sv
testbench/tb_cpu.sv

// ==== testbench/cpu_checker.sv ====
`timescale 1ns/1ns

module cpu_checker (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           run,
	input  logic           ext_req,
	input  logic           ext_gnt,
	input  cpu_pkg::word_t ext_rdata,
	input  logic           hlt,
	input  cpu_pkg::word_t pc,
	input  logic           check_en,
	input  cpu_pkg::word_t check_data,
	output int             value_errors,
	output int             other_errors,
	output int             checks
);

	// Nothing is checked before the first reset
	logic armed    = 1'b0;
	logic hlt_seen = 1'b0;
	cpu_pkg::word_t pc_at_hlt;

	initial begin
		value_errors = 0;
		other_errors = 0;
		checks       = 0;
	end

	//////////////////////////////
	// Sampled on the rising edge
	//////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			armed    = 1'b1;
			hlt_seen = 1'b0;
			if (hlt !== 1'b0) begin
				other_errors++;
				$display("Error at %0t ns: hlt is not low during reset", $time);
			end
		end else if (armed) begin
			// Idle core, the port must win at once
			if (!run && ext_gnt !== ext_req) begin
				other_errors++;
				$display("Error at %0t ns: ext_gnt does not follow ext_req while run is low",
					$time);
			end
			// Halt is sticky and freezes pc
			if (hlt_seen && hlt !== 1'b1) begin
				other_errors++;
				$display("Error at %0t ns: hlt dropped without a reset", $time);
			end
			if (hlt_seen && pc !== pc_at_hlt) begin
				value_errors++;
				$display("FAILED at %0t ns: pc moved after halt, 0x%04h instead of 0x%04h",
					$time, pc, pc_at_hlt);
			end
			if (hlt === 1'b1 && !hlt_seen) begin
				hlt_seen  = 1'b1;
				pc_at_hlt = pc;
			end
			// Read-back compare
			if (check_en) begin
				checks++;
				if (ext_gnt !== 1'b1) begin
					other_errors++;
					$display("Error at %0t ns: read-back request was not granted", $time);
				end else if (ext_rdata !== check_data) begin
					value_errors++;
					$display("FAILED at %0t ns: read-back 0x%04h, expected 0x%04h",
						$time, ext_rdata, check_data);
				end
			end
		end
	end

endmodule

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;

	localparam int addr_w     = 8;
	localparam int n_tests    = 9;
	localparam int prog_len   = 10;
	localparam int max_cycles = n_tests * 300;

	// Preloaded at every result address
	localparam cpu_pkg::word_t marker   = 16'h5a5a;
	localparam cpu_pkg::word_t hlt_word = 16'hf000;

	logic              clk = 1'b0;
	logic              rst_n, run, ext_req, ext_we;
	logic [addr_w-1:0] ext_addr;
	cpu_pkg::word_t    ext_wdata, ext_rdata, pc;
	logic              ext_gnt, hlt;
	// Expected read-back handed to the checker
	logic              check_en;
	cpu_pkg::word_t    check_data;
	int                value_errors, other_errors, checks;
	int                cycles;

	//////////////////////////////
	// Program table
	//////////////////////////////

	cpu_pkg::word_t    prog [n_tests][prog_len];
	cpu_pkg::word_t    data0 [n_tests];
	cpu_pkg::word_t    data1 [n_tests];
	logic [addr_w-1:0] res_addr [n_tests];
	cpu_pkg::word_t    expected [n_tests];

	// 4 ns period
	always #2 clk = ~clk;

	cpu #(.addr_w(addr_w)) cpu_i (
		.clk(clk), .rst_n(rst_n), .run(run),
		.ext_req(ext_req), .ext_we(ext_we), .ext_addr(ext_addr),
		.ext_wdata(ext_wdata), .ext_rdata(ext_rdata), .ext_gnt(ext_gnt),
		.hlt(hlt), .pc(pc)
	);

	cpu_checker checker_i (
		.clk(clk), .rst_n(rst_n), .run(run),
		.ext_req(ext_req), .ext_gnt(ext_gnt), .ext_rdata(ext_rdata),
		.hlt(hlt), .pc(pc),
		.check_en(check_en), .check_data(check_data),
		.value_errors(value_errors), .other_errors(other_errors), .checks(checks)
	);

	// Three register form, opcode rd rs rt
	function automatic cpu_pkg::word_t reg_instr(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	// Immediate form, opcode rd imm8
	function automatic cpu_pkg::word_t imm_instr(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	// r1 base 0xff80, r2 and r3 loaded, r5 = r2 op r3 stored at base + off
	task automatic pair_program(input int idx, input logic [3:0] op, input logic [3:0] off);
		prog[idx][0] = imm_instr(cpu_pkg::OP_LLB, 4'd1, 8'h80);
		prog[idx][1] = reg_instr(cpu_pkg::OP_LW, 4'd2, 4'd1, 4'd0);
		prog[idx][2] = reg_instr(cpu_pkg::OP_LW, 4'd3, 4'd1, 4'd1);
		prog[idx][3] = reg_instr(op, 4'd5, 4'd2, 4'd3);
		prog[idx][4] = reg_instr(cpu_pkg::OP_SW, 4'd5, 4'd1, off);
		prog[idx][5] = hlt_word;
		res_addr[idx] = 8'h80 + off;
	endtask

	// BEQZ on r2 = test, skips one SW when taken
	task automatic branch_program(input int idx, input logic [7:0] test, input logic [3:0] off);
		prog[idx][0] = imm_instr(cpu_pkg::OP_LLB, 4'd1, 8'h80);
		prog[idx][1] = imm_instr(cpu_pkg::OP_LLB, 4'd2, test);
		prog[idx][2] = reg_instr(cpu_pkg::OP_LW, 4'd3, 4'd1, 4'd0);
		prog[idx][3] = imm_instr(cpu_pkg::OP_BEQZ, 4'd2, 8'h01);
		prog[idx][4] = reg_instr(cpu_pkg::OP_SW, 4'd3, 4'd1, off);
		prog[idx][5] = hlt_word;
		res_addr[idx] = 8'h80 + off;
	endtask

	task automatic build_table();
		cpu_pkg::word_t r5, r6, r7;
		for (int i = 0; i < n_tests; i++) begin
			data0[i] = cpu_pkg::word_t'($urandom());
			data1[i] = cpu_pkg::word_t'($urandom());
			for (int j = 0; j < prog_len; j++)
				prog[i][j] = hlt_word;
		end
		// ADD with a negative LLB operand in r3
		pair_program(0, cpu_pkg::OP_ADD, 4'd2);
		prog[0][2] = imm_instr(cpu_pkg::OP_LLB, 4'd3, 8'h9c);
		expected[0] = data0[0] + 16'hff9c;
		pair_program(1, cpu_pkg::OP_SUB, 4'd3);
		expected[1] = data0[1] - data1[1];
		pair_program(2, cpu_pkg::OP_AND, 4'd4);
		expected[2] = data0[2] & data1[2];
		pair_program(3, cpu_pkg::OP_NOR, 4'd5);
		expected[3] = ~(data0[3] | data1[3]);
		// Back-to-back dependent chain
		prog[4][0] = imm_instr(cpu_pkg::OP_LLB, 4'd1, 8'h80);
		prog[4][1] = reg_instr(cpu_pkg::OP_LW, 4'd2, 4'd1, 4'd0);
		prog[4][2] = reg_instr(cpu_pkg::OP_LW, 4'd3, 4'd1, 4'd1);
		prog[4][3] = reg_instr(cpu_pkg::OP_ADD, 4'd5, 4'd2, 4'd3);
		prog[4][4] = reg_instr(cpu_pkg::OP_AND, 4'd6, 4'd5, 4'd2);
		prog[4][5] = reg_instr(cpu_pkg::OP_NOR, 4'd7, 4'd6, 4'd5);
		prog[4][6] = reg_instr(cpu_pkg::OP_SUB, 4'd8, 4'd7, 4'd3);
		prog[4][7] = reg_instr(cpu_pkg::OP_SW, 4'd8, 4'd1, 4'd6);
		res_addr[4] = 8'h86;
		r5 = data0[4] + data1[4];
		r6 = r5 & data0[4];
		r7 = ~(r6 | r5);
		expected[4] = r7 - data1[4];
		// Loads and a store against fetch traffic
		pair_program(5, cpu_pkg::OP_ADD, 4'd7);
		expected[5] = data0[5] + data1[5];
		// Taken branch leaves the marker, not-taken stores data0
		branch_program(6, 8'h00, 4'd8);
		expected[6] = marker;
		branch_program(7, 8'h01, 4'd9);
		expected[7] = data0[7];
		// Store after HLT must never land
		prog[8][0] = imm_instr(cpu_pkg::OP_LLB, 4'd1, 8'h80);
		prog[8][1] = reg_instr(cpu_pkg::OP_LW, 4'd2, 4'd1, 4'd1);
		prog[8][2] = reg_instr(cpu_pkg::OP_SW, 4'd2, 4'd1, 4'd10);
		prog[8][3] = hlt_word;
		prog[8][4] = reg_instr(cpu_pkg::OP_SW, 4'd1, 4'd1, 4'd10);
		res_addr[8] = 8'h8a;
		expected[8] = data1[8];
	endtask

	//////////////////////////////
	// External port and reset
	//////////////////////////////

	task automatic apply_reset();
		@(negedge clk);
		rst_n    = 1'b0;
		run      = 1'b0;
		ext_req  = 1'b0;
		ext_we   = 1'b0;
		check_en = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
	endtask

	// Write lands on the following rising edge
	task automatic write_word(input logic [addr_w-1:0] addr, input cpu_pkg::word_t data);
		@(negedge clk);
		ext_req   = 1'b1;
		ext_we    = 1'b1;
		ext_addr  = addr;
		ext_wdata = data;
	endtask

	// One read cycle, the checker compares at the rising edge
	task automatic read_expect(input logic [addr_w-1:0] addr, input cpu_pkg::word_t exp);
		@(negedge clk);
		ext_req    = 1'b1;
		ext_we     = 1'b0;
		ext_addr   = addr;
		check_en   = 1'b1;
		check_data = exp;
		@(negedge clk);
		ext_req  = 1'b0;
		check_en = 1'b0;
	endtask

	task automatic print_counts();
		$display("Checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
	endtask

	// Main sequence
	initial begin
		void'($urandom(61));
		rst_n      = 1'b1;
		run        = 1'b0;
		ext_req    = 1'b0;
		ext_we     = 1'b0;
		ext_addr   = '0;
		ext_wdata  = '0;
		check_en   = 1'b0;
		check_data = '0;
		build_table();
		for (int i = 0; i < n_tests; i++) begin
			apply_reset();
			for (int j = 0; j < prog_len; j++)
				write_word(j, prog[i][j]);
			write_word(8'h80, data0[i]);
			write_word(8'h81, data1[i]);
			write_word(res_addr[i], marker);
			// Port read-back before the core runs
			read_expect(res_addr[i], marker);
			read_expect(8'h80, data0[i]);
			run = 1'b1;
			do
				@(negedge clk);
			while (hlt !== 1'b1);
			// Halted core sits with run still high
			repeat (5) @(negedge clk);
			run = 1'b0;
			read_expect(res_addr[i], expected[i]);
		end
		@(negedge clk);
		print_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog, 300 cycles per table entry
	initial begin
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the core never finished all programs", cycles);
		print_counts();
		$display("Regression failed");
		$finish;
	end

endmodule
